// ==== src/csr_pkg.sv ====
package csr_pkg;

    localparam int XLEN = 32;

    // Core-side CSR operation
    typedef enum logic [1:0] {
        CSR_NOP   = 2'b00,
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_e;

    // Machine information registers, read only
    localparam logic [11:0] ADDR_MVENDORID = 12'hF11;
    localparam logic [11:0] ADDR_MARCHID   = 12'hF12;
    localparam logic [11:0] ADDR_MIMPID    = 12'hF13;
    localparam logic [11:0] ADDR_MHARTID   = 12'hF14;

    // Machine trap setup and handling
    localparam logic [11:0] ADDR_MSTATUS   = 12'h300;
    localparam logic [11:0] ADDR_MISA      = 12'h301;
    localparam logic [11:0] ADDR_MIE       = 12'h304;
    localparam logic [11:0] ADDR_MTVEC     = 12'h305;
    localparam logic [11:0] ADDR_MEPC      = 12'h341;
    localparam logic [11:0] ADDR_MCAUSE    = 12'h342;

    // Counter words
    localparam logic [11:0] ADDR_MCYCLE    = 12'hB00;
    localparam logic [11:0] ADDR_MCYCLEH   = 12'hB80;
    localparam logic [11:0] ADDR_MINSTRET  = 12'hB02;
    localparam logic [11:0] ADDR_MINSTRETH = 12'hB82;

    // Bit positions in the cnt_we strobe
    localparam int CNT_CYCLE_LO   = 0;
    localparam int CNT_CYCLE_HI   = 1;
    localparam int CNT_INSTRET_LO = 2;
    localparam int CNT_INSTRET_HI = 3;

    // RV32, I extension
    localparam logic [XLEN-1:0] MISA_RESET = 32'h40000100;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    // Trap and mret sequencer
    typedef enum logic [1:0] {
        TRAP_IDLE = 2'b00,
        TRAP_SAVE = 2'b01,
        TRAP_JUMP = 2'b10
    } trap_state_e;

endpackage

// ==== src/csr_regs.sv ====
`timescale 1ns/1ps

module csr_regs import csr_pkg::*; (
    input  logic            clk,
    input  logic            rst,

    input  csr_op_e         op,
    input  logic [11:0]     addr,
    input  logic [XLEN-1:0] wr_data,
    output logic [XLEN-1:0] rd_data,
    output logic            illegal,

    input  logic            trap_save,
    input  logic            mret_restore,
    input  logic [XLEN-1:0] save_pc,
    input  logic [XLEN-1:0] save_cause,

    input  logic [63:0]     mcycle,
    input  logic [63:0]     minstret,
    output logic [3:0]      cnt_we,
    output logic [XLEN-1:0] wr_value,

    output logic [XLEN-1:0] mtvec_q,
    output logic [XLEN-1:0] mepc_q
);

    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] misa;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;

    logic known;
    logic read_only;
    logic wr_en;

    // Address decode and read mux
    always_comb begin
        known     = 1'b1;
        read_only = 1'b0;
        case (addr)
            ADDR_MVENDORID, ADDR_MARCHID, ADDR_MIMPID, ADDR_MHARTID: begin
                read_only = 1'b1;
                rd_data   = '0;         // No vendor, arch or hart ids
            end
            ADDR_MSTATUS:   rd_data = mstatus;
            ADDR_MISA:      rd_data = misa;
            ADDR_MIE:       rd_data = mie;
            ADDR_MTVEC:     rd_data = mtvec;
            ADDR_MEPC:      rd_data = mepc;
            ADDR_MCAUSE:    rd_data = mcause;
            ADDR_MCYCLE:    rd_data = mcycle[31:0];
            ADDR_MCYCLEH:   rd_data = mcycle[63:32];
            ADDR_MINSTRET:  rd_data = minstret[31:0];
            ADDR_MINSTRETH: rd_data = minstret[63:32];
            default: begin
                known   = 1'b0;
                rd_data = '0;
            end
        endcase
    end

    // Any modifying op on a read-only or unknown address
    assign illegal = (op != CSR_NOP) && (!known || read_only);
    assign wr_en   = (op != CSR_NOP) && !illegal;

    always_comb begin
        case (op)
            CSR_WRITE: wr_value = wr_data;
            CSR_SET:   wr_value = rd_data | wr_data;
            CSR_CLEAR: wr_value = rd_data & ~wr_data;
            default:   wr_value = rd_data;
        endcase
    end

    // Counter words live in csr_counters
    assign cnt_we[CNT_CYCLE_LO]   = wr_en && (addr == ADDR_MCYCLE);
    assign cnt_we[CNT_CYCLE_HI]   = wr_en && (addr == ADDR_MCYCLEH);
    assign cnt_we[CNT_INSTRET_LO] = wr_en && (addr == ADDR_MINSTRET);
    assign cnt_we[CNT_INSTRET_HI] = wr_en && (addr == ADDR_MINSTRETH);

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= '0;
            misa    <= MISA_RESET;
            mie     <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (trap_save) begin
            mepc                      <= save_pc;
            mcause                    <= save_cause;
            mstatus[MSTATUS_MPIE_BIT] <= mstatus[MSTATUS_MIE_BIT];
            mstatus[MSTATUS_MIE_BIT]  <= 1'b0;
        end else if (mret_restore) begin
            mstatus[MSTATUS_MIE_BIT]  <= mstatus[MSTATUS_MPIE_BIT];
            mstatus[MSTATUS_MPIE_BIT] <= 1'b1;
        end else if (wr_en) begin
            case (addr)
                ADDR_MSTATUS: mstatus <= wr_value;
                ADDR_MISA:    misa    <= wr_value;
                ADDR_MIE:     mie     <= wr_value;
                ADDR_MTVEC:   mtvec   <= wr_value;
                ADDR_MEPC:    mepc    <= wr_value;
                ADDR_MCAUSE:  mcause  <= wr_value;
                default: ;              // Counter words or nothing
            endcase
        end
    end

    assign mtvec_q = mtvec;
    assign mepc_q  = mepc;

endmodule

// ==== src/csr_counters.sv ====
`timescale 1ns/1ps

module csr_counters import csr_pkg::*; (
    input  logic            clk,
    input  logic            rst,

    input  logic            retire,
    input  logic [3:0]      cnt_we,
    input  logic [XLEN-1:0] wr_value,

    output logic [63:0]     mcycle,
    output logic [63:0]     minstret
);

    // Written words replace the old ones, no increment on that edge
    function automatic logic [63:0] next_count(
        input logic [63:0]     cur,
        input logic            we_lo,
        input logic            we_hi,
        input logic            inc,
        input logic [XLEN-1:0] value
    );
        logic [63:0] nxt;
        nxt = cur;
        if (we_lo || we_hi) begin
            if (we_lo) begin
                nxt[31:0] = value;
            end
            if (we_hi) begin
                nxt[63:32] = value;
            end
        end else if (inc) begin
            nxt = cur + 64'd1;
        end
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle <= next_count(
                mcycle,
                cnt_we[CNT_CYCLE_LO],
                cnt_we[CNT_CYCLE_HI],
                1'b1,                   // Every clock
                wr_value
            );
            minstret <= next_count(
                minstret,
                cnt_we[CNT_INSTRET_LO],
                cnt_we[CNT_INSTRET_HI],
                retire,
                wr_value
            );
        end
    end

endmodule

// ==== src/trap_ctrl.sv ====
`timescale 1ns/1ps

module trap_ctrl import csr_pkg::*; (
    input  logic            clk,
    input  logic            rst,

    input  logic            trap_req,
    input  logic            mret_req,
    input  logic [XLEN-1:0] trap_pc,
    input  logic [XLEN-1:0] trap_cause,

    input  logic [XLEN-1:0] mtvec_q,
    input  logic [XLEN-1:0] mepc_q,

    output logic            busy,
    output logic            trap_save,
    output logic            mret_restore,
    output logic [XLEN-1:0] save_pc,
    output logic [XLEN-1:0] save_cause,

    output logic            redirect_valid,
    output logic [XLEN-1:0] redirect_pc
);

    trap_state_e state;
    logic        is_mret;
    logic        start;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] cause_q;

    // Requests while busy are dropped
    assign start = (state == TRAP_IDLE) && (trap_req || mret_req);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TRAP_IDLE;
            is_mret <= 1'b0;
        end else begin
            case (state)
                TRAP_IDLE: begin
                    if (start) begin
                        state   <= TRAP_SAVE;
                        is_mret <= !trap_req;   // Trap wins if both pulse
                    end
                end
                TRAP_SAVE: state <= TRAP_JUMP;
                TRAP_JUMP: state <= TRAP_IDLE;
                default:   state <= TRAP_IDLE;
            endcase
        end
    end

    // Trap payload
    always_ff @(posedge clk) begin
        if (start && trap_req) begin
            pc_q    <= trap_pc;
            cause_q <= trap_cause;
        end
    end

    assign busy = (state != TRAP_IDLE);

    assign trap_save    = (state == TRAP_SAVE) && !is_mret;
    assign mret_restore = (state == TRAP_SAVE) && is_mret;
    assign save_pc      = pc_q;
    assign save_cause   = cause_q;

    // Direct mode only, mode bits ignored
    assign redirect_valid = (state == TRAP_JUMP);
    assign redirect_pc    = is_mret ? mepc_q : {mtvec_q[XLEN-1:2], 2'b00};

endmodule

// ==== src/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit import csr_pkg::*; (
    input  logic            clk,
    input  logic            rst,

    input  csr_op_e         op,
    input  logic [11:0]     addr,
    input  logic [XLEN-1:0] wr_data,
    output logic [XLEN-1:0] rd_data,
    output logic            illegal,

    input  logic            retire,

    input  logic            trap_req,
    input  logic            mret_req,
    input  logic [XLEN-1:0] trap_pc,
    input  logic [XLEN-1:0] trap_cause,
    output logic            busy,
    output logic            redirect_valid,
    output logic [XLEN-1:0] redirect_pc
);

    logic            trap_save;
    logic            mret_restore;
    logic [XLEN-1:0] save_pc;
    logic [XLEN-1:0] save_cause;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [3:0]      cnt_we;
    logic [XLEN-1:0] wr_value;
    logic [63:0]     mcycle;
    logic [63:0]     minstret;

    csr_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .op           (op),
        .addr         (addr),
        .wr_data      (wr_data),
        .rd_data      (rd_data),
        .illegal      (illegal),
        .trap_save    (trap_save),
        .mret_restore (mret_restore),
        .save_pc      (save_pc),
        .save_cause   (save_cause),
        .mcycle       (mcycle),
        .minstret     (minstret),
        .cnt_we       (cnt_we),
        .wr_value     (wr_value),
        .mtvec_q      (mtvec_q),
        .mepc_q       (mepc_q)
    );

    csr_counters u_counters (
        .clk      (clk),
        .rst      (rst),
        .retire   (retire),
        .cnt_we   (cnt_we),
        .wr_value (wr_value),
        .mcycle   (mcycle),
        .minstret (minstret)
    );

    trap_ctrl u_trap (
        .clk            (clk),
        .rst            (rst),
        .trap_req       (trap_req),
        .mret_req       (mret_req),
        .trap_pc        (trap_pc),
        .trap_cause     (trap_cause),
        .mtvec_q        (mtvec_q),
        .mepc_q         (mepc_q),
        .busy           (busy),
        .trap_save      (trap_save),
        .mret_restore   (mret_restore),
        .save_pc        (save_pc),
        .save_cause     (save_cause),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

// ==== bench/csr_unit_props.sv ====
`timescale 1ns/1ps

module csr_unit_props import csr_pkg::*; (
    input logic    clk,
    input logic    rst,
    input csr_op_e op,
    input logic    illegal,
    input logic    trap_req,
    input logic    mret_req,
    input logic    busy,
    input logic    redirect_valid
);

    int fail_count = 0;

    // Redirect is a single-cycle pulse
    redirect_once: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |=> !redirect_valid)
        else begin fail_count++; $error("redirect_valid high two cycles in a row"); end

    redirect_timing: assert property (@(posedge clk) disable iff (rst)
        ((trap_req || mret_req) && !busy) |-> ##2 redirect_valid)
        else begin fail_count++; $error("redirect_valid not two cycles after request"); end

    // Core holds off while the sequencer runs
    quiet_while_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> (op == CSR_NOP && !trap_req && !mret_req))
        else begin fail_count++; $error("Request issued while busy"); end

    illegal_needs_op: assert property (@(posedge clk) disable iff (rst)
        (op == CSR_NOP) |-> !illegal)
        else begin fail_count++; $error("illegal raised without an op"); end

endmodule

bind csr_unit csr_unit_props u_props (.*);

// ==== bench/csr_unit_tb.sv ====
`timescale 1ns/1ps

module csr_unit_tb import csr_pkg::*; ();

    localparam logic [31:0] SEED = 32'hd292;
    localparam int RESET_CYCLES     = 5;
    localparam int REDIRECT_TIMEOUT = 10;

    logic            clk;
    logic            rst;
    csr_op_e         op;
    logic [11:0]     addr;
    logic [XLEN-1:0] wr_data;
    logic [XLEN-1:0] rd_data;
    logic            illegal;
    logic            retire;
    logic            trap_req;
    logic            mret_req;
    logic [XLEN-1:0] trap_pc;
    logic [XLEN-1:0] trap_cause;
    logic            busy;
    logic            redirect_valid;
    logic [XLEN-1:0] redirect_pc;

    // Reference model state
    logic [XLEN-1:0] m_mstatus, m_misa, m_mie, m_mtvec, m_mepc, m_mcause;
    logic [63:0]     m_cycle;
    logic [63:0]     m_instret;

    int errors = 0;
    int checks = 0;

    csr_unit dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Counters follow the driven inputs, which are stable at the edge
    always @(posedge clk) begin
        if (rst) begin
            m_cycle   <= '0;
            m_instret <= '0;
        end else begin
            if (op == CSR_WRITE && addr == ADDR_MCYCLE)
                m_cycle[31:0] <= wr_data;
            else if (op == CSR_WRITE && addr == ADDR_MCYCLEH)
                m_cycle[63:32] <= wr_data;
            else
                m_cycle <= m_cycle + 64'd1;
            if (op == CSR_WRITE && addr == ADDR_MINSTRET)
                m_instret[31:0] <= wr_data;
            else if (op == CSR_WRITE && addr == ADDR_MINSTRETH)
                m_instret[63:32] <= wr_data;
            else if (retire)
                m_instret <= m_instret + 64'd1;
        end
    end

    // Ids first, then trap CSRs, then counter words
    function automatic logic [11:0] known_addr(input int k);
        case (k)
            0: return ADDR_MVENDORID;
            1: return ADDR_MARCHID;
            2: return ADDR_MIMPID;
            3: return ADDR_MHARTID;
            4: return ADDR_MSTATUS;
            5: return ADDR_MISA;
            6: return ADDR_MIE;
            7: return ADDR_MTVEC;
            8: return ADDR_MEPC;
            9: return ADDR_MCAUSE;
            10: return ADDR_MCYCLE;
            11: return ADDR_MCYCLEH;
            12: return ADDR_MINSTRET;
            default: return ADDR_MINSTRETH;
        endcase
    endfunction

    function automatic logic is_known(input logic [11:0] a);
        logic found;
        found = 1'b0;
        for (int k = 0; k < 14; k++) begin
            if (known_addr(k) == a)
                found = 1'b1;
        end
        return found;
    endfunction

    function automatic logic [XLEN-1:0] expected_read(input logic [11:0] a);
        case (a)
            ADDR_MSTATUS:   return m_mstatus;
            ADDR_MISA:      return m_misa;
            ADDR_MIE:       return m_mie;
            ADDR_MTVEC:     return m_mtvec;
            ADDR_MEPC:      return m_mepc;
            ADDR_MCAUSE:    return m_mcause;
            ADDR_MCYCLE:    return m_cycle[31:0];
            ADDR_MCYCLEH:   return m_cycle[63:32];
            ADDR_MINSTRET:  return m_instret[31:0];
            ADDR_MINSTRETH: return m_instret[63:32];
            default:        return '0;   // Ids and unknown addresses
        endcase
    endfunction

    function automatic logic [XLEN-1:0] merge(input csr_op_e o, input logic [XLEN-1:0] old,
                                              input logic [XLEN-1:0] d);
        case (o)
            CSR_WRITE: return d;
            CSR_SET:   return old | d;
            CSR_CLEAR: return old & ~d;
            default:   return old;
        endcase
    endfunction

    function automatic csr_op_e rand_op();
        case ($urandom_range(0, 2))
            0: return CSR_WRITE;
            1: return CSR_SET;
            default: return CSR_CLEAR;
        endcase
    endfunction

    task automatic model_store(input logic [11:0] a, input logic [XLEN-1:0] v);
        case (a)
            ADDR_MSTATUS: m_mstatus = v;
            ADDR_MISA:    m_misa    = v;
            ADDR_MIE:     m_mie     = v;
            ADDR_MTVEC:   m_mtvec   = v;
            ADDR_MEPC:    m_mepc    = v;
            ADDR_MCAUSE:  m_mcause  = v;
            default: ;                  // Counters tracked at the clock edge
        endcase
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_redirect(input string name, input logic [XLEN-1:0] got,
                                  input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // One op, old value checked mid-cycle, model updated after the edge
    task automatic csr_access(input csr_op_e o, input logic [11:0] a, input logic [XLEN-1:0] d,
                              input logic exp_illegal);
        logic [XLEN-1:0] old;
        op      = o;
        addr    = a;
        wr_data = d;
        #1;
        old = expected_read(a);
        check_flag("illegal", illegal, exp_illegal);
        check_data($sformatf("rd_data[%03h]", a), rd_data, old);
        next_cycle();
        op = CSR_NOP;
        if (!exp_illegal)
            model_store(a, merge(o, old, d));
    endtask

    task automatic read_check(input logic [11:0] a, output logic [XLEN-1:0] v);
        addr = a;
        #1;
        v = rd_data;
        check_data($sformatf("rd_data[%03h]", a), rd_data, expected_read(a));
        next_cycle();
    endtask

    task automatic wait_redirect();
        int waited;
        waited = 0;
        while (!redirect_valid && waited < REDIRECT_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (!redirect_valid) begin
            errors++;
            $display("Timeout: redirect_valid did not rise within %0d cycles", REDIRECT_TIMEOUT);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("Test %s done, %0d errors", name, errors - errors_before);
    endtask

    initial begin
        logic [XLEN-1:0] d;
        logic [XLEN-1:0] v;
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] cause;
        logic [11:0]     a;
        logic [31:0]     r;
        int              n;
        int              retired;
        int              start_errors;

        rst = 1'b1;
        op = CSR_NOP;
        addr = '0;
        wr_data = '0;
        retire = 1'b0;
        trap_req = 1'b0;
        mret_req = 1'b0;
        trap_pc = '0;
        trap_cause = '0;
        {m_mstatus, m_mie, m_mtvec, m_mepc, m_mcause} = '0;
        m_misa = MISA_RESET;
        r = $urandom(SEED);

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        start_errors = errors;
        for (int k = 0; k < 14; k++)
            read_check(known_addr(k), v);
        report_test("reset values", start_errors);

        start_errors = errors;
        repeat (200) begin
            csr_access(rand_op(), known_addr($urandom_range(4, 9)), $urandom(), 1'b0);
            read_check(addr, v);        // Read back the same CSR
        end
        report_test("writable CSRs", start_errors);

        start_errors = errors;
        repeat (40) begin
            r = $urandom();
            if (r[0]) begin
                a = known_addr($urandom_range(0, 3));
            end else begin
                a = r[12:1];
                while (is_known(a)) begin
                    r = $urandom();
                    a = r[11:0];
                end
            end
            csr_access(rand_op(), a, $urandom(), 1'b1);
            read_check(a, v);
        end
        report_test("read-only and unknown", start_errors);

        start_errors = errors;
        d = $urandom();
        csr_access(CSR_WRITE, ADDR_MCYCLE, d, 1'b0);
        read_check(ADDR_MCYCLE, v);
        check_data("mcycle", v, d);
        n = $urandom_range(3, 20);
        repeat (n) next_cycle();
        read_check(ADDR_MCYCLE, v);
        check_data("mcycle", v, d + 32'd1 + n);
        read_check(ADDR_MINSTRET, base);
        retired = 0;
        repeat (60) begin
            r = $urandom();
            retire = r[0];
            if (r[0])
                retired++;
            next_cycle();
        end
        retire = 1'b0;
        read_check(ADDR_MINSTRET, v);
        check_data("minstret", v, base + retired);
        report_test("counters", start_errors);

        start_errors = errors;
        csr_access(CSR_WRITE, ADDR_MTVEC, $urandom(), 1'b0);
        csr_access(CSR_SET, ADDR_MSTATUS, 32'h1 << MSTATUS_MIE_BIT, 1'b0);
        pc = $urandom();
        cause = $urandom();
        trap_req = 1'b1;
        trap_pc = pc;
        trap_cause = cause;
        next_cycle();
        trap_req = 1'b0;
        check_flag("busy", busy, 1'b1);     // Save cycle
        wait_redirect();
        check_redirect("redirect_pc", redirect_pc, m_mtvec & ~32'h3);
        m_mepc = pc;
        m_mcause = cause;
        m_mstatus[MSTATUS_MPIE_BIT] = m_mstatus[MSTATUS_MIE_BIT];
        m_mstatus[MSTATUS_MIE_BIT] = 1'b0;
        next_cycle();
        check_flag("busy", busy, 1'b0);
        read_check(ADDR_MEPC, v);
        read_check(ADDR_MCAUSE, v);
        read_check(ADDR_MSTATUS, v);
        report_test("trap entry", start_errors);

        start_errors = errors;
        csr_access(CSR_WRITE, ADDR_MEPC, $urandom(), 1'b0);
        mret_req = 1'b1;
        next_cycle();
        mret_req = 1'b0;
        wait_redirect();
        check_redirect("redirect_pc", redirect_pc, m_mepc);
        m_mstatus[MSTATUS_MIE_BIT] = m_mstatus[MSTATUS_MPIE_BIT];
        m_mstatus[MSTATUS_MPIE_BIT] = 1'b1;
        next_cycle();
        read_check(ADDR_MSTATUS, v);
        report_test("mret", start_errors);

        n = dut.u_props.fail_count;
        $display("%0d checks, %0d errors, %0d assertion failures", checks, errors, n);
        if (errors == 0 && n == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
src/csr_pkg.sv
src/csr_regs.sv
src/csr_counters.sv
src/trap_ctrl.sv
src/csr_unit.sv
bench/csr_unit_props.sv
bench/csr_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= csr_unit_tb
RTL_TOP   ?= csr_unit
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
RTL_SRCS  ?= src/csr_pkg.sv src/csr_regs.sv src/csr_counters.sv src/trap_ctrl.sv src/csr_unit.sv
TB_SRCS   ?= bench/csr_unit_props.sv bench/csr_unit_tb.sv
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(RTL_SRCS) $(TB_SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	-./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then echo "Result: FAIL, run incomplete"; exit 1; fi
	@echo "Result: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
